/* rtl/fma_cfg.svh */
// Binary16 only. The derived widths hold for this format alone and must be revised with it
`ifndef FMA_CFG_SVH
`define FMA_CFG_SVH

// ----------------------------------------------------------------------
// Encoded format
// ----------------------------------------------------------------------
`define FMA_EXP_BITS 5
`define FMA_MAN_BITS 10
`define FMA_WIDTH (1 + `FMA_EXP_BITS + `FMA_MAN_BITS)
`define FMA_BIAS 15

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
// Precision p counts the implicit bit
`define FMA_PREC (`FMA_MAN_BITS + 1)
// Adder holds addend, product and the two guard slots in 3p+4 bits
`define FMA_SUM_WIDTH (3 * `FMA_PREC + 4)
// Leading zeros are searched in the lower 2p+3 sum bits
`define FMA_LOWER_SUM_WIDTH (2 * `FMA_PREC + 3)
// Signed internal exponent, two bits of headroom over the field
`define FMA_EXP_WIDTH (`FMA_EXP_BITS + 2)
// Enough for shifts up to 3p+4
`define FMA_SHAMT_WIDTH 6

// Operation tag carried along the pipe
`define FMA_TAG_BITS 4

`endif

/* rtl/fma_pkg.sv */
// Types for the binary16 FMA. Only RNE and RTZ exist and the status has no UF or DZ
`include "fma_cfg.svh"

package fma_pkg;

  typedef struct packed {
    logic                     sign;
    logic [`FMA_EXP_BITS-1:0] exponent;
    logic [`FMA_MAN_BITS-1:0] mantissa;
  } fp_t;

  typedef enum logic [0:0] {
    RNE = 1'b0,
    RTZ = 1'b1
  } roundmode_e;

  // op_mod flips the addend sign on top of these
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } operation_e;

  typedef struct packed {
    logic nv;
    logic of;
    logic nx;
  } status_t;

  typedef logic [`FMA_TAG_BITS-1:0] tag_t;

  // State handed from the adder to normalization
  typedef struct packed {
    logic                        eff_sub;
    // Biased exponents, two's complement
    logic [`FMA_EXP_WIDTH-1:0]   exp_product;
    logic [`FMA_EXP_WIDTH-1:0]   exp_diff;
    logic [`FMA_EXP_WIDTH-1:0]   tent_exp;
    logic [`FMA_SHAMT_WIDTH-1:0] addend_shamt;
    // Addend bits lost in alignment
    logic                        sticky;
    // Magnitude of a*b+c, already sign fixed
    logic [`FMA_SUM_WIDTH-1:0]   sum;
    logic                        final_sign;
    roundmode_e                  rnd_mode;
    // Bypass for NaN and infinity
    logic                        is_special;
    fp_t                         special_result;
    status_t                     special_status;
    tag_t                        tag;
  } sum_payload_t;

  typedef struct packed {
    fp_t     result;
    status_t status;
    tag_t    tag;
  } result_payload_t;

endpackage

/* rtl/fma_prepare.sv */
// Purely combinational front half. op_i must be a known encoding, and MUL ignores op_mod_i
`timescale 1ns/1ns
`include "fma_cfg.svh"

module fma_prepare (
  input  fma_pkg::fp_t          operand_a_i,
  input  fma_pkg::fp_t          operand_b_i,
  input  fma_pkg::fp_t          operand_c_i,
  input  fma_pkg::roundmode_e   rnd_mode_i,
  input  fma_pkg::operation_e   op_i,
  input  logic                  op_mod_i,
  input  fma_pkg::tag_t         tag_i,
  output fma_pkg::sum_payload_t payload_o
);

  localparam int Prec = `FMA_PREC;
  localparam int Bias = `FMA_BIAS;
  localparam int SumW = `FMA_SUM_WIDTH;
  localparam int EW   = `FMA_EXP_WIDTH;
  localparam int ShW  = `FMA_SHAMT_WIDTH;

  // ----------------------------------------------------------------------
  // Operation select
  // ----------------------------------------------------------------------
  fma_pkg::fp_t op_a, op_b, op_c;

  always_comb begin : op_select
    op_a = operand_a_i;
    op_b = operand_b_i;
    op_c = operand_c_i;
    // Subtracting flavours
    op_c.sign = operand_c_i.sign ^ op_mod_i;
    case (op_i)
      // Negated product
      fma_pkg::FNMSUB: op_a.sign = ~operand_a_i.sign;
      // Multiplicand forced to +1.0
      fma_pkg::ADD:    op_a = '{sign: 1'b0, exponent: Bias[`FMA_EXP_BITS-1:0], mantissa: '0};
      // Addend forced to -0 so a zero product keeps its own sign
      fma_pkg::MUL:    op_c = '{sign: 1'b1, exponent: '0, mantissa: '0};
      default: ;
    endcase
    assert (!$isunknown(op_i)) else $error("operation code is unknown");
  end

  // ----------------------------------------------------------------------
  // Classification
  // ----------------------------------------------------------------------
  fma_pkg::fp_t [2:0] ops;
  logic [2:0] is_zero, is_sub, is_norm, is_inf, is_nan, is_snan;

  assign ops = {op_c, op_b, op_a};

  for (genvar i = 0; i < 3; i++) begin : gen_class
    logic exp_zero, exp_max, man_zero;
    assign exp_zero   = (ops[i].exponent == '0);
    assign exp_max    = &ops[i].exponent;
    assign man_zero   = (ops[i].mantissa == '0);
    assign is_zero[i] = exp_zero & man_zero;
    assign is_sub[i]  = exp_zero & ~man_zero;
    assign is_norm[i] = ~exp_zero & ~exp_max;
    assign is_inf[i]  = exp_max & man_zero;
    assign is_nan[i]  = exp_max & ~man_zero;
    // Cleared quiet bit marks a signalling NaN
    assign is_snan[i] = is_nan[i] & ~ops[i].mantissa[`FMA_MAN_BITS-1];
  end

  logic eff_sub, tentative_sign;

  // Product and addend of opposite sign
  assign eff_sub        = op_a.sign ^ op_b.sign ^ op_c.sign;
  assign tentative_sign = op_a.sign ^ op_b.sign;

  // ----------------------------------------------------------------------
  // Special cases
  // ----------------------------------------------------------------------
  fma_pkg::fp_t    special_result;
  fma_pkg::status_t special_status;
  logic            is_special;

  always_comb begin : special_cases
    // Canonical quiet NaN unless overridden
    special_result = '{sign: 1'b0, exponent: '1, mantissa: {1'b1, {(`FMA_MAN_BITS-1){1'b0}}}};
    special_status = '0;
    is_special     = 1'b1;
    if ((is_inf[0] && is_zero[1]) || (is_zero[0] && is_inf[1])) begin
      // inf*0 is invalid even next to a quiet NaN
      special_status.nv = 1'b1;
    end else if (|is_nan) begin
      special_status.nv = |is_snan;
    end else if ((is_inf[0] || is_inf[1]) && is_inf[2] && eff_sub) begin
      special_status.nv = 1'b1;
    end else if (is_inf[0] || is_inf[1]) begin
      special_result = '{sign: tentative_sign, exponent: '1, mantissa: '0};
    end else if (is_inf[2]) begin
      special_result = '{sign: op_c.sign, exponent: '1, mantissa: '0};
    end else begin
      is_special = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Exponent path
  // ----------------------------------------------------------------------
  logic signed [EW-1:0] exp_a, exp_b, exp_c;
  logic signed [EW-1:0] exp_addend, exp_product, exp_diff, tent_exp;
  logic [ShW-1:0]       addend_shamt;

  assign exp_a = EW'(op_a.exponent);
  assign exp_b = EW'(op_b.exponent);
  assign exp_c = EW'(op_c.exponent);

  // Subnormals and zero share biased exponent 1
  assign exp_addend  = exp_c + EW'(!is_norm[2]);
  // Zero product sits at the minimum exponent
  assign exp_product = (is_zero[0] || is_zero[1]) ? EW'(2 - Bias)
                     : EW'(exp_a + is_sub[0] + exp_b + is_sub[1] - Bias);
  assign exp_diff    = exp_addend - exp_product;
  assign tent_exp    = (exp_diff > 0) ? exp_addend : exp_product;

  always_comb begin : shift_amount
    if (exp_diff <= -(2 * Prec + 1)) begin
      // Addend lands only in the sticky bit
      addend_shamt = ShW'(SumW);
    end else if (exp_diff <= Prec + 2) begin
      addend_shamt = ShW'(Prec + 3 - exp_diff);
    end else begin
      // Product lands only below the addend
      addend_shamt = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Product and aligned addend
  // ----------------------------------------------------------------------
  logic [Prec-1:0]   man_a, man_b, man_c;
  logic [2*Prec-1:0] product;
  logic [SumW-1:0]   product_shifted, addend_after_shift, addend_shifted;
  logic [Prec-1:0]   addend_sticky_bits;
  logic              sticky_before_add;

  assign man_a   = {is_norm[0], op_a.mantissa};
  assign man_b   = {is_norm[1], op_b.mantissa};
  assign man_c   = {is_norm[2], op_c.mantissa};
  assign product = man_a * man_b;

  // Two low zero bits leave room for round and sticky
  assign product_shifted = SumW'({product, 2'b00});

  // Addend starts left of the product and moves right, overflow collapses to sticky
  assign {addend_after_shift, addend_sticky_bits} = {man_c, {SumW{1'b0}}} >> addend_shamt;
  assign sticky_before_add = |addend_sticky_bits;
  assign addend_shifted    = eff_sub ? ~addend_after_shift : addend_after_shift;

  // ----------------------------------------------------------------------
  // Adder and sign fix
  // ----------------------------------------------------------------------
  logic [SumW:0] sum_raw, sum_mag;
  logic          sum_carry, inject_carry, final_sign;

  // Two's complement only when no sticky bit borrows
  assign inject_carry = eff_sub & ~sticky_before_add;
  assign sum_raw      = {1'b0, product_shifted} + {1'b0, addend_shifted} + (SumW + 1)'(inject_carry);
  assign sum_carry    = sum_raw[SumW];
  // Missing carry on a subtraction means the addend won
  assign sum_mag      = (eff_sub && !sum_carry) ? -sum_raw : sum_raw;
  assign final_sign   = eff_sub ? (sum_carry == tentative_sign) : tentative_sign;

  always_comb begin : pack
    payload_o.eff_sub        = eff_sub;
    payload_o.exp_product    = exp_product;
    payload_o.exp_diff       = exp_diff;
    payload_o.tent_exp       = tent_exp;
    payload_o.addend_shamt   = addend_shamt;
    payload_o.sticky         = sticky_before_add;
    payload_o.sum            = sum_mag[SumW-1:0];
    payload_o.final_sign     = final_sign;
    payload_o.rnd_mode       = rnd_mode_i;
    payload_o.is_special     = is_special;
    payload_o.special_result = special_result;
    payload_o.special_status = special_status;
    payload_o.tag            = tag_i;
  end

endmodule

/* rtl/stage_buffer.sv */
// Single-entry register slice. Ready is combinational from downstream, and the payload has no reset
`timescale 1ns/1ns

module stage_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  input  payload_t payload_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t payload_o,
  input  logic     ready_i
);

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ready_i | ~valid_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  // Bubbles do not disturb the held data
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      payload_o <= payload_i;
    end
  end

  // ----------------------------------------------------------------------
  // Handshake check
  // ----------------------------------------------------------------------
  // Upstream holds a refused offer until it is taken
  assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_i && !ready_o) |=> (valid_i && $stable(payload_i)))
    else $error("input changed while stalled");

endmodule

/* rtl/fma_normalize_round.sv */
// Combinational back half. Rounds RNE or RTZ only, and reports no underflow flag
`timescale 1ns/1ns
`include "fma_cfg.svh"

module fma_normalize_round (
  input  fma_pkg::sum_payload_t    payload_i,
  output fma_pkg::result_payload_t result_o
);

  localparam int ExpBits = `FMA_EXP_BITS;
  localparam int ManBits = `FMA_MAN_BITS;
  localparam int Prec    = `FMA_PREC;
  localparam int SumW    = `FMA_SUM_WIDTH;
  localparam int LowW    = `FMA_LOWER_SUM_WIDTH;
  localparam int EW      = `FMA_EXP_WIDTH;
  localparam int ShW     = `FMA_SHAMT_WIDTH;
  localparam int AbsW    = ExpBits + ManBits;

  // Leading zeros from the MSB, LowW when the input is all zero
  function automatic logic [ShW-1:0] count_lz(input logic [LowW-1:0] v);
    logic [ShW-1:0] cnt;
    logic           seen;
    cnt  = '0;
    seen = 1'b0;
    for (int i = LowW - 1; i >= 0; i--) begin
      if (v[i]) begin
        seen = 1'b1;
      end else if (!seen) begin
        cnt = cnt + 1'b1;
      end
    end
    return cnt;
  endfunction

  // ----------------------------------------------------------------------
  // Normalization
  // ----------------------------------------------------------------------
  logic signed [EW-1:0] exp_prod, exp_diff, tent_exp, lz_sgn;
  logic signed [EW-1:0] norm_exp, final_exp;
  logic [ShW-1:0]       lz, norm_shamt;
  logic                 lz_zero, sticky_after_norm;
  logic [SumW:0]        sum_shifted;
  logic [Prec:0]        final_man;
  logic [LowW-1:0]      sticky_bits;

  assign exp_prod = payload_i.exp_product;
  assign exp_diff = payload_i.exp_diff;
  assign tent_exp = payload_i.tent_exp;
  assign lz       = count_lz(payload_i.sum[LowW-1:0]);
  assign lz_zero  = (payload_i.sum[LowW-1:0] == '0);
  assign lz_sgn   = EW'(lz);

  always_comb begin : norm_shift
    if ((exp_diff <= 0) || (payload_i.eff_sub && (exp_diff <= 2))) begin
      // Product anchored or cancelled, the count decides
      if ((exp_prod - lz_sgn + 1 >= 0) && !lz_zero) begin
        norm_shamt = ShW'(Prec + 2 + lz);
        norm_exp   = EW'(exp_prod - lz_sgn + 1);
      end else begin
        // Subnormal, stop at the minimum exponent
        norm_shamt = ShW'(Prec + 2 + exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment
      norm_shamt = payload_i.addend_shamt;
      norm_exp   = tent_exp;
    end
  end

  assign sum_shifted = {1'b0, payload_i.sum} << norm_shamt;

  // Leading one may still sit one place off
  always_comb begin : small_norm
    {final_man, sticky_bits} = sum_shifted[SumW-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SumW]) begin
      // Carry out
      {final_man, sticky_bits} = sum_shifted[SumW:1];
      final_exp                = norm_exp + EW'(1);
    end else if (sum_shifted[SumW-1]) begin
      final_exp = norm_exp;
    end else if (norm_exp > 1) begin
      {final_man, sticky_bits} = {sum_shifted[SumW-2:0], 1'b0};
      final_exp                = norm_exp - EW'(1);
    end else begin
      final_exp = '0;
    end
  end

  assign sticky_after_norm = (|sticky_bits) | payload_i.sticky;

  // ----------------------------------------------------------------------
  // Rounding
  // ----------------------------------------------------------------------
  logic               of_before, of_after, round_up, exact_zero, rounded_sign;
  logic [ExpBits-1:0] pre_exp;
  logic [ManBits-1:0] pre_man;
  logic [AbsW-1:0]    pre_abs, rounded_abs;
  logic [1:0]         round_sticky;

  // Exponent all ones is already out of range
  assign of_before = (final_exp >= (2 ** ExpBits) - 1);
  // Largest normal so rounding picks inf or max finite
  assign pre_exp      = of_before ? ExpBits'(2 ** ExpBits - 2) : final_exp[ExpBits-1:0];
  assign pre_man      = of_before ? '1 : final_man[ManBits:1];
  assign pre_abs      = {pre_exp, pre_man};
  assign round_sticky = of_before ? 2'b11 : {final_man[0], sticky_after_norm};

  // Ties go to even
  assign round_up = (payload_i.rnd_mode == fma_pkg::RNE) && round_sticky[1]
                  && (round_sticky[0] || pre_abs[0]);
  // Mantissa carry walks into the exponent
  assign rounded_abs = pre_abs + AbsW'(round_up);
  assign of_after    = &rounded_abs[AbsW-1:ManBits];

  // x - x gives +0
  assign exact_zero   = (pre_abs == '0) && (round_sticky == 2'b00);
  assign rounded_sign = (exact_zero && payload_i.eff_sub) ? 1'b0 : payload_i.final_sign;

  // ----------------------------------------------------------------------
  // Result selection
  // ----------------------------------------------------------------------
  fma_pkg::fp_t     regular_result;
  fma_pkg::status_t regular_status;

  assign regular_result    = {rounded_sign, rounded_abs};
  assign regular_status.nv = 1'b0;
  assign regular_status.of = of_before | of_after;
  assign regular_status.nx = (|round_sticky) | of_before | of_after;

  assign result_o.result = payload_i.is_special ? payload_i.special_result : regular_result;
  assign result_o.status = payload_i.is_special ? payload_i.special_status : regular_status;
  assign result_o.tag    = payload_i.tag;

  // Bypass from the front end never signals overflow next to invalid
  always_comb begin : special_check
    assert ($isunknown(payload_i.special_status)
            || !(payload_i.special_status.nv && payload_i.special_status.of))
      else $error("special status has invalid and overflow together");
  end

endmodule

/* rtl/fma_unit.sv */
// Binary16 fused multiply-add with fixed 2-cycle latency, RNE/RTZ only and no flush
`timescale 1ns/1ns
`include "fma_cfg.svh"

module fma_unit (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // Operands and operation
  input  logic [`FMA_WIDTH-1:0]    operand_a_i,
  input  logic [`FMA_WIDTH-1:0]    operand_b_i,
  input  logic [`FMA_WIDTH-1:0]    operand_c_i,
  input  fma_pkg::roundmode_e      rnd_mode_i,
  input  fma_pkg::operation_e      op_i,
  input  logic                     op_mod_i,
  input  fma_pkg::tag_t            tag_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  // Result side
  output logic [`FMA_WIDTH-1:0]    result_o,
  output fma_pkg::status_t         status_o,
  output fma_pkg::tag_t            tag_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);

  fma_pkg::sum_payload_t    prep_payload, mid_payload;
  fma_pkg::result_payload_t norm_result, out_payload;
  logic                     mid_valid, out_stage_ready;

  // Front half, same cycle as acceptance
  fma_prepare u_prepare (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .rnd_mode_i  (rnd_mode_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .tag_i       (tag_i),
    .payload_o   (prep_payload)
  );

  stage_buffer #(
    .payload_t (fma_pkg::sum_payload_t)
  ) u_mid (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (in_valid_i),
    .payload_i (prep_payload),
    .ready_o   (in_ready_o),
    .valid_o   (mid_valid),
    .payload_o (mid_payload),
    .ready_i   (out_stage_ready)
  );

  fma_normalize_round u_norm (
    .payload_i (mid_payload),
    .result_o  (norm_result)
  );

  // Output register drives the ports directly
  stage_buffer #(
    .payload_t (fma_pkg::result_payload_t)
  ) u_out (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (mid_valid),
    .payload_i (norm_result),
    .ready_o   (out_stage_ready),
    .valid_o   (out_valid_o),
    .payload_o (out_payload),
    .ready_i   (out_ready_i)
  );

  assign result_o = out_payload.result;
  assign status_o = out_payload.status;
  assign tag_o    = out_payload.tag;

endmodule

/* tests/fma_model.svh */
// Binary16 a*b+c reference, exact in 128-bit fixed point with one rounding, RNE and RTZ only
`ifndef FMA_MODEL_SVH
`define FMA_MODEL_SVH

localparam logic [15:0] canonical_nan = 16'h7e00;

function automatic logic is_nan_val(input fma_pkg::fp_t x);
  return (&x.exponent) && (x.mantissa != '0);
endfunction

function automatic logic is_snan_val(input fma_pkg::fp_t x);
  return is_nan_val(x) && !x.mantissa[9];
endfunction

function automatic logic is_inf_val(input fma_pkg::fp_t x);
  return (&x.exponent) && (x.mantissa == '0);
endfunction

function automatic logic is_zero_val(input fma_pkg::fp_t x);
  return (x.exponent == '0) && (x.mantissa == '0);
endfunction

// Significand with the hidden bit, subnormals get none
function automatic logic [10:0] significand(input fma_pkg::fp_t x);
  return {(x.exponent != '0), x.mantissa};
endfunction

// Subnormals share exponent 1 with the smallest normals
function automatic int eff_exp(input fma_pkg::fp_t x);
  return (x.exponent == '0) ? 1 : int'(x.exponent);
endfunction

// Magnitude in units of 2^-48, never zero here
function automatic fma_pkg::result_payload_t round_to_half(input logic sign,
    input logic [127:0] mag, input fma_pkg::roundmode_e rnd);
  fma_pkg::result_payload_t r;
  int                       p;
  int                       e;
  int                       s;
  logic [127:0]             q;
  logic [127:0]             rem;
  logic [127:0]             half;
  logic [31:0]              abs_val;
  logic                     up;
  r = '0;
  p = -1;
  for (int i = 127; i >= 0; i--) begin
    if (p < 0 && mag[i]) begin
      p = i;
    end
  end
  // Leading bit at 2^(p-48) means biased exponent p-33
  e = (p - 33 < 1) ? 1 : p - 33;
  // Quantum of that binade in 2^-48 units
  s    = e + 23;
  q    = mag >> s;
  rem  = mag & ((128'd1 << s) - 128'd1);
  half = 128'd1 << (s - 1);
  up   = (rnd == fma_pkg::RNE) && ((rem > half) || ((rem == half) && q[0]));
  q    = q + 128'(up);
  // A carry to 2048 lands on the next exponent by itself
  abs_val = 32'((e - 1) * 1024) + q[31:0];
  if (abs_val >= 32'h7c00) begin
    r.result    = {sign, (rnd == fma_pkg::RNE) ? 15'h7c00 : 15'h7bff};
    r.status.of = 1'b1;
    r.status.nx = 1'b1;
  end else begin
    r.result    = {sign, abs_val[14:0]};
    r.status.nx = (rem != '0);
  end
  return r;
endfunction

function automatic fma_pkg::result_payload_t model_fma(input fma_pkg::fp_t a_in,
    input fma_pkg::fp_t b_in, input fma_pkg::fp_t c_in, input fma_pkg::roundmode_e rnd,
    input fma_pkg::operation_e op, input logic op_mod, input fma_pkg::tag_t tag);
  fma_pkg::fp_t             a;
  fma_pkg::fp_t             b;
  fma_pkg::fp_t             c;
  fma_pkg::result_payload_t r;
  fma_pkg::result_payload_t rounded;
  logic                     ps;
  logic                     cs;
  logic signed [127:0]      prod;
  logic signed [127:0]      addend;
  logic signed [127:0]      total;
  a      = a_in;
  b      = b_in;
  c      = c_in;
  c.sign = c_in.sign ^ op_mod;
  case (op)
    fma_pkg::FNMSUB: a.sign = ~a_in.sign;
    fma_pkg::ADD:    a = 16'h3c00;
    fma_pkg::MUL:    c = 16'h8000;
    default: ;
  endcase
  r     = '0;
  r.tag = tag;
  ps    = a.sign ^ b.sign;
  cs    = c.sign;
  if ((is_inf_val(a) && is_zero_val(b)) || (is_zero_val(a) && is_inf_val(b))) begin
    r.result    = canonical_nan;
    r.status.nv = 1'b1;
  end else if (is_nan_val(a) || is_nan_val(b) || is_nan_val(c)) begin
    r.result    = canonical_nan;
    r.status.nv = is_snan_val(a) || is_snan_val(b) || is_snan_val(c);
  end else if ((is_inf_val(a) || is_inf_val(b)) && is_inf_val(c) && (ps != cs)) begin
    r.result    = canonical_nan;
    r.status.nv = 1'b1;
  end else if (is_inf_val(a) || is_inf_val(b)) begin
    r.result = {ps, 15'h7c00};
  end else if (is_inf_val(c)) begin
    r.result = {cs, 15'h7c00};
  end else begin
    // Exact product and addend in 2^-48 units
    prod   = 128'(significand(a)) * 128'(significand(b));
    prod   = prod << (eff_exp(a) + eff_exp(b) - 2);
    addend = 128'(significand(c)) << (eff_exp(c) + 23);
    if (ps) prod = -prod;
    if (cs) addend = -addend;
    total = prod + addend;
    if (total == 0) begin
      // Only two zeros of equal sign keep a negative zero
      r.result = {ps & cs, 15'h0000};
    end else begin
      rounded  = (total < 0) ? round_to_half(1'b1, -total, rnd) : round_to_half(1'b0, total, rnd);
      r.result = rounded.result;
      r.status = rounded.status;
    end
  end
  return r;
endfunction

`endif

/* tests/tb_fma_unit.sv */
// Expects the fixed 2-cycle latency and a 4-bit tag that wraps, so tags alone do not prove order
`timescale 1ns/1ns

module tb_fma_unit;

  logic                clk;
  logic                rst;
  fma_pkg::fp_t        op_a;
  fma_pkg::fp_t        op_b;
  fma_pkg::fp_t        op_c;
  fma_pkg::roundmode_e rnd_mode;
  fma_pkg::operation_e op;
  logic                op_mod;
  fma_pkg::tag_t       tag;
  logic                in_valid;
  logic                in_ready;
  logic [15:0]         result;
  fma_pkg::status_t    status;
  fma_pkg::tag_t       out_tag;
  logic                out_valid;
  logic                out_ready;

  typedef struct {
    fma_pkg::result_payload_t expected;
    int                       accept_cycle;
    logic                     timed;
  } pending_t;

  pending_t    pending_q[$];
  logic [31:0] lcg_state;
  int          cycle = 0;
  int          sent = 0;
  int          received = 0;
  // Random back-pressure on the output when set
  logic        stall_mode;
  // Burst items whose latency is checked
  logic        timed_mode;

  // Directed specials as {a, b, c}
  logic [47:0] special_list [7] = '{
    48'h7e00_3c00_3c00, 48'h7d00_3c00_0000, 48'h7c00_0000_7e00, 48'h7c00_3c00_fc00,
    48'h3c00_7c00_4000, 48'h4000_4000_fc00, 48'h3c00_3c00_7c01
  };

  `include "fma_model.svh"

  fma_unit DUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .operand_c_i (op_c),
    .rnd_mode_i  (rnd_mode),
    .op_i        (op),
    .op_mod_i    (op_mod),
    .tag_i       (tag),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .result_o    (result),
    .status_o    (status),
    .tag_o       (out_tag),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ----------------------------------------------------------------------
  // Random numbers and checks
  // ----------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_fp(input string name, input fma_pkg::fp_t got, input fma_pkg::fp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input fma_pkg::status_t got,
      input fma_pkg::status_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_tag(input string name, input fma_pkg::tag_t got, input fma_pkg::tag_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  // Exponent field 0 to 30, a quarter of them near 1.0 so sums cancel
  function automatic fma_pkg::fp_t rand_finite();
    logic [31:0]  r;
    fma_pkg::fp_t x;
    r          = next_rand();
    x.sign     = r[31];
    x.exponent = 5'(r[30:26] % 31);
    x.mantissa = r[25:16];
    if (r[15:14] == 2'b00) x.exponent = 5'd13 + 5'(r[12:11]);
    return x;
  endfunction

  function automatic fma_pkg::fp_t rand_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[31:29])
      3'd0: return {r[28], 15'h7c00};
      3'd1: return {r[28], 15'h7e00};
      // Signalling NaN, payload kept nonzero
      3'd2: return {r[28], 5'h1f, 1'b0, r[24:16] | 9'h001};
      default: return rand_finite();
    endcase
  endfunction

  // Next edge plus the drive delay
  task automatic advance_cycle();
    logic [31:0] r;
    @(posedge clk);
    #1;
    r = next_rand();
    if (stall_mode) out_ready = (r[31:30] != 2'b00);
  endtask

  task automatic send_op(input fma_pkg::fp_t a, input fma_pkg::fp_t b, input fma_pkg::fp_t c,
      input fma_pkg::roundmode_e rm, input fma_pkg::operation_e o, input logic m);
    pending_t entry;
    int       wait_cycles;
    op_a           = a;
    op_b           = b;
    op_c           = c;
    rnd_mode       = rm;
    op             = o;
    op_mod         = m;
    tag            = sent[3:0];
    in_valid       = 1'b1;
    entry.expected = model_fma(a, b, c, rm, o, m, sent[3:0]);
    entry.timed    = timed_mode;
    wait_cycles    = 0;
    @(negedge clk);
    while (!in_ready) begin
      wait_cycles++;
      if (wait_cycles > 100) report_failure("timeout waiting for in_ready_o");
      advance_cycle();
      @(negedge clk);
    end
    if (timed_mode && wait_cycles != 0) report_failure("input stalled during back-to-back burst");
    entry.accept_cycle = cycle;
    pending_q.push_back(entry);
    sent++;
    advance_cycle();
  endtask

  task automatic send_random(input logic any_class);
    logic [31:0]  r;
    fma_pkg::fp_t a;
    fma_pkg::fp_t b;
    fma_pkg::fp_t c;
    r = next_rand();
    a = any_class ? rand_operand() : rand_finite();
    b = any_class ? rand_operand() : rand_finite();
    c = any_class ? rand_operand() : rand_finite();
    send_op(a, b, c, fma_pkg::roundmode_e'(r[31]), fma_pkg::operation_e'(r[30:29]), r[28]);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (received != sent) begin
      waited++;
      if (waited > 1000) report_failure("timeout waiting for results to drain");
      advance_cycle();
    end
  endtask

  // ----------------------------------------------------------------------
  // Output monitor, sampled mid-cycle
  // ----------------------------------------------------------------------
  initial begin : monitor
    pending_t         head;
    fma_pkg::fp_t     held_result;
    fma_pkg::status_t held_status;
    fma_pkg::tag_t    held_tag;
    logic             stalled;
    stalled = 1'b0;
    forever begin
      @(negedge clk);
      if (stalled) begin
        if (!out_valid) report_failure("out_valid_o dropped while the output was stalled");
        check_fp("result_o held", result, held_result);
        check_status("status_o held", status, held_status);
        check_tag("tag_o held", out_tag, held_tag);
      end
      stalled = 1'b0;
      if (!rst && out_valid) begin
        if (pending_q.size() == 0) report_failure("result arrived with no operation pending");
        if (out_ready) begin
          head = pending_q.pop_front();
          check_fp("result_o", result, head.expected.result);
          check_status("status_o", status, head.expected.status);
          check_tag("tag_o", out_tag, head.expected.tag);
          if (head.timed && (cycle - head.accept_cycle != 2)) begin
            report_failure($sformatf("MISMATCH t=%0t latency got %0d expected 2",
                                     $time, cycle - head.accept_cycle));
          end
          received++;
        end else begin
          held_result = result;
          held_status = status;
          held_tag    = out_tag;
          stalled     = 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0]  r;
    fma_pkg::fp_t a;
    fma_pkg::fp_t c;
    lcg_state  = 32'h1e3b;
    rst        = 1'b1;
    op_a       = '0;
    op_b       = '0;
    op_c       = '0;
    rnd_mode   = fma_pkg::RNE;
    op         = fma_pkg::FMADD;
    op_mod     = 1'b0;
    tag        = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    stall_mode = 1'b0;
    timed_mode = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    if (out_valid !== 1'b0) report_failure("out_valid_o is not low after reset");
    if (in_ready !== 1'b1) report_failure("in_ready_o is not high after reset");
    advance_cycle();

    // Back-to-back finite operands with the output always ready
    timed_mode = 1'b1;
    repeat (40) send_random(1'b0);
    in_valid   = 1'b0;
    timed_mode = 1'b0;
    wait_drain();

    // NaN, infinity and inf*0 under every operation
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 7; i++) begin
        send_op(special_list[i][47:32], special_list[i][31:16], special_list[i][15:0],
                fma_pkg::roundmode_e'(k[0]), fma_pkg::operation_e'(k), 1'b0);
      end
    end

    // c cancels a*2 exactly, both signs of op_mod
    for (int i = 0; i < 16; i++) begin
      a          = rand_finite();
      a.exponent = 5'd1 + 5'(a.exponent % 5'd28);
      c          = {~a.sign, a.exponent + 5'd1, a.mantissa};
      send_op(a, 16'h4000, c, fma_pkg::roundmode_e'(i[0]), fma_pkg::FMADD, 1'b0);
      c.sign = a.sign;
      send_op(a, 16'h4000, c, fma_pkg::roundmode_e'(i[0]), fma_pkg::FMADD, 1'b1);
    end

    // Random back-pressure and input gaps
    stall_mode = 1'b1;
    repeat (300) begin
      r = next_rand();
      if (r[31:30] == 2'b00) begin
        in_valid = 1'b0;
        advance_cycle();
      end
      send_random(1'b1);
    end
    in_valid = 1'b0;
    wait_drain();

    // Every result is out, so both stages must be empty again
    if ((out_valid !== 1'b0) || (in_ready !== 1'b1)) begin
      report_failure("pipeline is not empty after the last result");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* sources.f */
+incdir+rtl
+incdir+tests
rtl/fma_pkg.sv
rtl/fma_prepare.sv
rtl/stage_buffer.sv
rtl/fma_normalize_round.sv
rtl/fma_unit.sv
tests/tb_fma_unit.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fma_unit -f sources.f -o sim_fma_unit

./obj_dir/sim_fma_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
grep -q "Result: PASSED" sim.log
